// File: rtl/dcache_pkg.sv
package dcache_pkg;

	// one block is one word
	localparam int BLOCK_BITS = 64;
	localparam int ADDR_BITS = 16;

	// zero means no tag, or a refused command
	typedef logic [3:0] mem_tag_t;

	typedef enum logic [1:0]
	{
		MEM_NONE = 2'd0,
		MEM_LOAD = 2'd1,
		MEM_STORE = 2'd2
	} mem_command_t;

endpackage

// File: rtl/dcache_if.sv
`timescale 1ns/1ps

interface dcache_if import dcache_pkg::*; #(
	parameter int INDEX_BITS = 3
) ();

	localparam int TAG_BITS = ADDR_BITS - INDEX_BITS;

	// request fields and lookup strobes
	logic [INDEX_BITS-1:0] index;
	logic [TAG_BITS-1:0] tag;
	logic read_enable;
	logic write_enable;
	logic [BLOCK_BITS-1:0] write_data;

	// miss handling
	logic fill_arm;
	mem_tag_t response;
	logic evict;

	// lookup result and victim of the indexed set
	logic hit;
	logic victim_dirty;
	logic [TAG_BITS-1:0] victim_tag;
	logic [BLOCK_BITS-1:0] victim_data;
	logic fill_done;

	modport ctrl (
		output index, tag, read_enable, write_enable, write_data, fill_arm, response, evict,
		input hit, victim_dirty, victim_tag, victim_data, fill_done
	);

	modport mem (
		input index, tag, read_enable, write_enable, write_data, fill_arm, response, evict,
		output hit, victim_dirty, victim_tag, victim_data, fill_done
	);

endinterface

// File: rtl/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; #(
	parameter int INDEX_BITS = 3
) (
	input logic clock,
	input logic reset,
	input logic req_valid,
	input logic req_store,
	input logic [ADDR_BITS-1:0] req_addr,
	input logic [BLOCK_BITS-1:0] req_data,
	input mem_tag_t mem_response,
	output logic busy,
	output mem_command_t mem_command,
	output logic [ADDR_BITS-1:0] mem_addr,
	output logic [BLOCK_BITS-1:0] mem_store_data,
	output logic done,
	output logic was_load,
	output logic miss_event,
	output logic writeback_event,
	dcache_if.ctrl bus
);

	localparam int TAG_BITS = ADDR_BITS - INDEX_BITS;

	typedef enum logic [2:0] {IDLE, LOOKUP, WRITEBACK, FETCH, FILL_WAIT} state_t;

	state_t state;
	state_t next_state;
	logic accept;
	logic first_lookup;
	logic fetch_open;
	logic store_q;
	logic [TAG_BITS-1:0] tag_q;
	logic [INDEX_BITS-1:0] index_q;
	logic [BLOCK_BITS-1:0] data_q;

	assign accept = (state == IDLE) && req_valid;
	assign busy = (state != IDLE);
	assign was_load = !store_q;

	assign bus.index = index_q;
	assign bus.tag = tag_q;
	assign bus.write_data = data_q;
	assign bus.response = mem_response;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= IDLE;
			first_lookup <= 1'b0;
		end
		else
		begin
			state <= next_state;
			if (accept)
				first_lookup <= 1'b1;
			else if (state == LOOKUP)
				first_lookup <= 1'b0;
		end
	end

	// split the word address at accept
	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			store_q <= req_store;
			tag_q <= req_addr[ADDR_BITS-1:INDEX_BITS];
			index_q <= req_addr[INDEX_BITS-1:0];
			data_q <= req_data;
		end
	end

	always_comb
	begin
		next_state = state;
		bus.read_enable = 1'b0;
		bus.write_enable = 1'b0;
		bus.fill_arm = 1'b0;
		bus.evict = 1'b0;
		mem_command = MEM_NONE;
		mem_addr = '0;
		mem_store_data = '0;
		done = 1'b0;
		miss_event = 1'b0;
		writeback_event = 1'b0;
		case (state)
			IDLE:
			begin
				if (req_valid)
					next_state = LOOKUP;
			end
			LOOKUP:
			begin
				bus.read_enable = !store_q;
				bus.write_enable = store_q;
				miss_event = !bus.hit && first_lookup;
				if (bus.hit)
				begin
					done = 1'b1;
					next_state = IDLE;
				end
				else if (bus.victim_dirty)
					next_state = WRITEBACK;
				else if (store_q)
				begin
					// clean victim takes the store in place
					done = 1'b1;
					next_state = IDLE;
				end
				else
					next_state = FETCH;
			end
			WRITEBACK:
			begin
				mem_command = MEM_STORE;
				mem_addr = {bus.victim_tag, index_q};
				mem_store_data = bus.victim_data;
				if (mem_response != '0)
				begin
					bus.evict = 1'b1;
					writeback_event = 1'b1;
					next_state = store_q ? LOOKUP : FETCH;
				end
			end
			FETCH:
			begin
				mem_command = MEM_LOAD;
				mem_addr = {tag_q, index_q};
				if (mem_response != '0)
				begin
					bus.fill_arm = 1'b1;
					next_state = FILL_WAIT;
				end
			end
			FILL_WAIT:
			begin
				if (bus.fill_done)
					next_state = LOOKUP;
			end
			default:
				next_state = IDLE;
		endcase
	end

	// open from arming a fill until its install
	always_ff @(posedge clock)
	begin
		if (reset)
			fetch_open <= 1'b0;
		else if (bus.fill_arm)
			fetch_open <= 1'b1;
		else if (bus.fill_done)
			fetch_open <= 1'b0;
	end

	idle_quiet_a: assert property (@(posedge clock) disable iff (reset)
		!busy |-> mem_command == MEM_NONE);

	fetch_done_a: assert property (@(posedge clock) disable iff (reset)
		fetch_open |-> !done);

endmodule

// File: rtl/dcache_mem.sv
`timescale 1ns/1ps

module dcache_mem import dcache_pkg::*; #(
	parameter int INDEX_BITS = 3
) (
	input logic clock,
	input logic reset,
	input mem_tag_t mem_tag,
	input logic [BLOCK_BITS-1:0] mem_load_data,
	output logic [BLOCK_BITS-1:0] read_data,
	output logic lookup_hit,
	dcache_if.mem bus
);

	localparam int SETS = 1 << INDEX_BITS;
	localparam int TAG_BITS = ADDR_BITS - INDEX_BITS;

	logic [BLOCK_BITS-1:0] data [SETS][2];
	logic [TAG_BITS-1:0] tags [SETS][2];
	logic [SETS-1:0][1:0] valid;
	logic [SETS-1:0][1:0] dirty;
	mem_tag_t [SETS-1:0][1:0] pending;
	// lru bit names the way to replace next
	logic [SETS-1:0] lru;

	logic [1:0] match;
	logic hit_any;
	logic hit_way;
	logic victim;
	logic store_alloc;
	logic fill_hit;
	logic [INDEX_BITS-1:0] fill_set;
	logic fill_way;

	always_comb
	begin
		for (int w = 0; w < 2; w++)
			match[w] = valid[bus.index][w] && (tags[bus.index][w] == bus.tag);
	end

	assign hit_any = |match;
	assign hit_way = match[1];
	assign victim = lru[bus.index];
	assign store_alloc = bus.write_enable && !hit_any && !dirty[bus.index][victim];

	assign bus.hit = hit_any;
	assign bus.victim_dirty = dirty[bus.index][victim];
	assign bus.victim_tag = tags[bus.index][victim];
	assign bus.victim_data = data[bus.index][victim];
	assign bus.fill_done = fill_hit;

	assign read_data = data[bus.index][hit_way];
	assign lookup_hit = hit_any && (bus.read_enable || bus.write_enable);

	// find the way waiting on this response tag
	always_comb
	begin
		fill_hit = 1'b0;
		fill_set = '0;
		fill_way = 1'b0;
		for (int s = 0; s < SETS; s++)
		begin
			for (int w = 0; w < 2; w++)
			begin
				if ((mem_tag != '0) && (pending[s][w] == mem_tag))
				begin
					fill_hit = 1'b1;
					fill_set = INDEX_BITS'(s);
					fill_way = 1'(w);
				end
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid <= '0;
			dirty <= '0;
			pending <= '0;
			lru <= '0;
		end
		else
		begin
			if (lookup_hit)
				lru[bus.index] <= !hit_way;
			if (bus.write_enable && hit_any)
				dirty[bus.index][hit_way] <= 1'b1;
			if (store_alloc)
			begin
				valid[bus.index][victim] <= 1'b1;
				dirty[bus.index][victim] <= 1'b1;
				lru[bus.index] <= !victim;
			end
			if (bus.evict)
				dirty[bus.index][victim] <= 1'b0;
			// way stays invalid until its data returns
			if (bus.fill_arm)
			begin
				pending[bus.index][victim] <= bus.response;
				valid[bus.index][victim] <= 1'b0;
				dirty[bus.index][victim] <= 1'b0;
			end
			if (fill_hit)
			begin
				valid[fill_set][fill_way] <= 1'b1;
				dirty[fill_set][fill_way] <= 1'b0;
				pending[fill_set][fill_way] <= '0;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (bus.write_enable && hit_any)
			data[bus.index][hit_way] <= bus.write_data;
		if (store_alloc)
		begin
			data[bus.index][victim] <= bus.write_data;
			tags[bus.index][victim] <= bus.tag;
		end
		if (bus.fill_arm)
			tags[bus.index][victim] <= bus.tag;
		if (fill_hit)
			data[fill_set][fill_way] <= mem_load_data;
	end

	for (genvar s = 0; s < SETS; s++)
	begin : g_set_check
		unique_tag_a: assert property (@(posedge clock) disable iff (reset)
			(valid[s][0] && valid[s][1]) |-> (tags[s][0] != tags[s][1]));
	end

	one_access_a: assert property (@(posedge clock) disable iff (reset)
		!(bus.read_enable && bus.write_enable));

endmodule

// File: rtl/dcache_resp.sv
`timescale 1ns/1ps

module dcache_resp import dcache_pkg::*; (
	input logic clock,
	input logic reset,
	input logic done,
	input logic was_load,
	input logic [BLOCK_BITS-1:0] read_data,
	input logic lookup_hit,
	input logic miss_event,
	input logic writeback_event,
	output logic resp_valid,
	output logic [BLOCK_BITS-1:0] resp_data,
	output logic [15:0] hit_count,
	output logic [15:0] miss_count,
	output logic [15:0] writeback_count
);

	// current request has missed once already
	logic missed;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			resp_valid <= 1'b0;
			missed <= 1'b0;
			hit_count <= '0;
			miss_count <= '0;
			writeback_count <= '0;
		end
		else
		begin
			resp_valid <= done;
			if (done)
				missed <= 1'b0;
			else if (miss_event)
				missed <= 1'b1;
			if (done && lookup_hit && !missed)
				hit_count <= hit_count + 16'd1;
			if (miss_event)
				miss_count <= miss_count + 16'd1;
			if (writeback_event)
				writeback_count <= writeback_count + 16'd1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (done)
			resp_data <= was_load ? read_data : '0;
	end

	resp_pulse_a: assert property (@(posedge clock) disable iff (reset)
		resp_valid |=> !resp_valid);

endmodule

// File: rtl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; #(
	parameter int INDEX_BITS = 3
) (
	input logic clock,
	input logic reset,
	input logic req_valid,
	input logic req_store,
	input logic [ADDR_BITS-1:0] req_addr,
	input logic [BLOCK_BITS-1:0] req_data,
	output logic busy,
	output logic resp_valid,
	output logic [BLOCK_BITS-1:0] resp_data,
	output mem_command_t mem_command,
	output logic [ADDR_BITS-1:0] mem_addr,
	output logic [BLOCK_BITS-1:0] mem_store_data,
	input mem_tag_t mem_response,
	input mem_tag_t mem_tag,
	input logic [BLOCK_BITS-1:0] mem_load_data,
	output logic [15:0] hit_count,
	output logic [15:0] miss_count,
	output logic [15:0] writeback_count
);

	logic done;
	logic was_load;
	logic miss_event;
	logic writeback_event;
	logic [BLOCK_BITS-1:0] read_data;
	logic lookup_hit;

	dcache_if #(.INDEX_BITS(INDEX_BITS)) bus ();

	dcache_ctrl #(.INDEX_BITS(INDEX_BITS)) u_ctrl (
		.clock(clock),
		.reset(reset),
		.req_valid(req_valid),
		.req_store(req_store),
		.req_addr(req_addr),
		.req_data(req_data),
		.mem_response(mem_response),
		.busy(busy),
		.mem_command(mem_command),
		.mem_addr(mem_addr),
		.mem_store_data(mem_store_data),
		.done(done),
		.was_load(was_load),
		.miss_event(miss_event),
		.writeback_event(writeback_event),
		.bus(bus.ctrl)
	);

	dcache_mem #(.INDEX_BITS(INDEX_BITS)) u_mem (
		.clock(clock),
		.reset(reset),
		.mem_tag(mem_tag),
		.mem_load_data(mem_load_data),
		.read_data(read_data),
		.lookup_hit(lookup_hit),
		.bus(bus.mem)
	);

	dcache_resp u_resp (
		.clock(clock),
		.reset(reset),
		.done(done),
		.was_load(was_load),
		.read_data(read_data),
		.lookup_hit(lookup_hit),
		.miss_event(miss_event),
		.writeback_event(writeback_event),
		.resp_valid(resp_valid),
		.resp_data(resp_data),
		.hit_count(hit_count),
		.miss_count(miss_count),
		.writeback_count(writeback_count)
	);

endmodule

// File: include/mem_init.svh
// power-up contents of a memory word, every address bit shows in the word
function automatic logic [63:0] initial_word(input logic [15:0] addr);
	return {addr ^ 16'ha5c3, ~addr, addr + 16'h1234, addr[7:0], addr[15:8]};
endfunction

// File: test/mem_model.sv
`timescale 1ns/1ps

module mem_model import dcache_pkg::*; #(
	parameter int LOAD_DELAY = 5
) (
	input logic clock,
	input logic reset,
	input logic refuse,
	input mem_command_t mem_command,
	input logic [ADDR_BITS-1:0] mem_addr,
	input logic [BLOCK_BITS-1:0] mem_store_data,
	output mem_tag_t mem_response,
	output mem_tag_t mem_tag,
	output logic [BLOCK_BITS-1:0] mem_load_data
);

	`include "mem_init.svh"

	// sparse, only written words are held
	logic [BLOCK_BITS-1:0] words [logic [ADDR_BITS-1:0]];
	mem_tag_t next_tag;
	mem_tag_t return_tag;
	logic [BLOCK_BITS-1:0] return_data;
	int countdown;

	function automatic logic [BLOCK_BITS-1:0] read_word(input logic [ADDR_BITS-1:0] addr);
		if (words.exists(addr))
			return words[addr];
		return initial_word(addr);
	endfunction

	assign mem_response = ((mem_command != MEM_NONE) && !refuse) ? next_tag : '0;

	always @(posedge clock)
	begin
		mem_tag <= '0;
		mem_load_data <= '0;
		if (reset)
		begin
			next_tag <= 4'd1;
			countdown <= 0;
		end
		else
		begin
			if (countdown == 1)
			begin
				mem_tag <= return_tag;
				mem_load_data <= return_data;
			end
			if (countdown > 0)
				countdown <= countdown - 1;
			if (mem_response != '0)
			begin
				// tags run 1 to 15, zero is never handed out
				next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
				if (mem_command == MEM_STORE)
					words[mem_addr] = mem_store_data;
				else
				begin
					return_tag <= mem_response;
					return_data <= read_word(mem_addr);
					countdown <= LOAD_DELAY;
				end
			end
		end
	end

endmodule

// File: test/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

	`include "mem_init.svh"

	localparam int INDEX_BITS = 3;
	localparam int TAG_BITS = ADDR_BITS - INDEX_BITS;
	localparam int SETS = 1 << INDEX_BITS;
	localparam int LOAD_DELAY = 5;
	localparam int DIRECTED_REQUESTS = 7;
	localparam int RANDOM_REQUESTS = 300;
	localparam int TIMEOUT_CYCLES =
		(DIRECTED_REQUESTS + RANDOM_REQUESTS) * (2 * LOAD_DELAY + 20);

	logic clock;
	logic reset;
	logic req_valid;
	logic req_store;
	logic [ADDR_BITS-1:0] req_addr;
	logic [BLOCK_BITS-1:0] req_data;
	logic busy;
	logic resp_valid;
	logic [BLOCK_BITS-1:0] resp_data;
	mem_command_t mem_command;
	logic [ADDR_BITS-1:0] mem_addr;
	logic [BLOCK_BITS-1:0] mem_store_data;
	mem_tag_t mem_response;
	mem_tag_t mem_tag;
	logic [BLOCK_BITS-1:0] mem_load_data;
	logic [15:0] hit_count;
	logic [15:0] miss_count;
	logic [15:0] writeback_count;
	logic refuse;
	logic refusal_on;

	// reference cache and its memory
	logic [TAG_BITS-1:0] model_tag [SETS][2];
	logic [BLOCK_BITS-1:0] model_data [SETS][2];
	logic model_valid [SETS][2];
	logic model_dirty [SETS][2];
	logic model_lru [SETS];
	logic [BLOCK_BITS-1:0] model_mem [logic [ADDR_BITS-1:0]];
	int model_hits = 0;
	int model_misses = 0;
	int model_writebacks = 0;

	// memory commands as {command, address, data}
	logic [81:0] expected_q [$];
	logic [81:0] observed_q [$];
	logic [81:0] last_store;

	logic [31:0] lcg_state = 32'd30;
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	dcache_top #(.INDEX_BITS(INDEX_BITS)) DUT (
		.clock(clock),
		.reset(reset),
		.req_valid(req_valid),
		.req_store(req_store),
		.req_addr(req_addr),
		.req_data(req_data),
		.busy(busy),
		.resp_valid(resp_valid),
		.resp_data(resp_data),
		.mem_command(mem_command),
		.mem_addr(mem_addr),
		.mem_store_data(mem_store_data),
		.mem_response(mem_response),
		.mem_tag(mem_tag),
		.mem_load_data(mem_load_data),
		.hit_count(hit_count),
		.miss_count(miss_count),
		.writeback_count(writeback_count)
	);

	mem_model #(.LOAD_DELAY(LOAD_DELAY)) memory (
		.clock(clock),
		.reset(reset),
		.refuse(refuse),
		.mem_command(mem_command),
		.mem_addr(mem_addr),
		.mem_store_data(mem_store_data),
		.mem_response(mem_response),
		.mem_tag(mem_tag),
		.mem_load_data(mem_load_data)
	);

	function automatic logic [15:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	function automatic logic [BLOCK_BITS-1:0] model_word(input logic [ADDR_BITS-1:0] addr);
		if (model_mem.exists(addr))
			return model_mem[addr];
		return initial_word(addr);
	endfunction

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// two-way write-allocate write-back model where lru names the way to replace
	task automatic model_access(input logic store, input logic [ADDR_BITS-1:0] addr,
		input logic [BLOCK_BITS-1:0] data, output logic [BLOCK_BITS-1:0] result);
		logic [INDEX_BITS-1:0] set;
		logic [TAG_BITS-1:0] tag;
		logic way;
		logic found;
		set = addr[INDEX_BITS-1:0];
		tag = addr[ADDR_BITS-1:INDEX_BITS];
		found = 1'b1;
		way = 1'b0;
		if (model_valid[set][0] && (model_tag[set][0] == tag))
			way = 1'b0;
		else if (model_valid[set][1] && (model_tag[set][1] == tag))
			way = 1'b1;
		else
			found = 1'b0;
		if (found)
			model_hits++;
		else
		begin
			model_misses++;
			way = model_lru[set];
			if (model_dirty[set][way])
			begin
				model_mem[{model_tag[set][way], set}] = model_data[set][way];
				expected_q.push_back({MEM_STORE, model_tag[set][way], set, model_data[set][way]});
				model_writebacks++;
			end
			if (!store)
			begin
				model_data[set][way] = model_word(addr);
				expected_q.push_back({MEM_LOAD, addr, {BLOCK_BITS{1'b0}}});
			end
			model_tag[set][way] = tag;
			model_valid[set][way] = 1'b1;
			model_dirty[set][way] = 1'b0;
		end
		if (store)
		begin
			model_data[set][way] = data;
			model_dirty[set][way] = 1'b1;
		end
		model_lru[set] = !way;
		result = store ? '0 : model_data[set][way];
	endtask

	task automatic compare_commands(input string name);
		logic [81:0] expected;
		logic [81:0] observed;
		check_value({name, " command count"}, 128'(expected_q.size()),
			128'(observed_q.size()));
		while ((expected_q.size() > 0) && (observed_q.size() > 0))
		begin
			expected = expected_q.pop_front();
			observed = observed_q.pop_front();
			check_value({name, " command"}, 128'(expected), 128'(observed));
		end
		expected_q.delete();
		observed_q.delete();
	endtask

	task automatic run_request(input string name, input logic store,
		input logic [ADDR_BITS-1:0] addr, input logic [BLOCK_BITS-1:0] data,
		output int latency);
		logic [BLOCK_BITS-1:0] expected;
		model_access(store, addr, data, expected);
		@(posedge clock);
		#1;
		req_valid = 1'b1;
		req_store = store;
		req_addr = addr;
		req_data = data;
		@(posedge clock);
		#1;
		req_valid = 1'b0;
		latency = 0;
		do
		begin
			@(negedge clock);
			latency++;
			if (!resp_valid)
				check_value({name, " busy"}, 128'(1), 128'(busy));
		end
		while (!resp_valid);
		check_value({name, " busy at response"}, 128'(0), 128'(busy));
		check_value({name, " data"}, 128'(expected), 128'(resp_data));
		compare_commands(name);
	endtask

	// four tags per set from a small address pool
	task automatic random_traffic(input string name, input int count);
		logic [15:0] bits;
		logic [ADDR_BITS-1:0] addr;
		logic [BLOCK_BITS-1:0] data;
		int latency;
		for (int i = 0; i < count; i++)
		begin
			bits = next_random();
			addr = {11'd0, bits[5:4], bits[3:1]};
			data = {next_random(), next_random(), next_random(), next_random()};
			run_request(name, bits[0], addr, data, latency);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("test %s: %s", name, (errors == errors_before) ? "ok" : "failed");
	endtask

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock)
	begin
		#1;
		refuse = refusal_on && (next_random() < 16'd16384);
	end

	// accepted commands sampled mid-cycle
	always @(negedge clock)
	begin
		if (!reset && (mem_command != MEM_NONE) && (mem_response != '0))
		begin
			observed_q.push_back({mem_command, mem_addr, mem_store_data});
			if (mem_command == MEM_STORE)
				last_store = {mem_command, mem_addr, mem_store_data};
		end
	end

	always @(posedge clock)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout: the DUT stopped responding after %0d cycles", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial
	begin
		int mark;
		int hits;
		int latency;
		logic [BLOCK_BITS-1:0] stored;
		reset = 1'b1;
		req_valid = 1'b0;
		req_store = 1'b0;
		req_addr = '0;
		req_data = '0;
		refusal_on = 1'b0;
		refuse = 1'b0;
		last_store = '0;
		model_valid = '{default: '0};
		model_dirty = '{default: '0};
		model_lru = '{default: '0};
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;

		mark = errors;
		run_request("cold load miss", 1'b0, 16'h0123, '0, latency);
		check_value("cold miss count", 128'(1), 128'(miss_count));
		report_test("cold load miss", mark);

		mark = errors;
		run_request("store miss", 1'b1, 16'h0204, 64'h1122_3344_5566_7788, latency);
		hits = int'(hit_count);
		run_request("load hit", 1'b0, 16'h0204, '0, latency);
		check_value("load hit value", 128'(64'h1122_3344_5566_7788), 128'(resp_data));
		check_value("hit latency", 128'(2), 128'(latency));
		check_value("hit count step", 128'(hits + 1), 128'(hit_count));
		report_test("store then load hit", mark);

		// three tags in set 5 with the first one dirty
		mark = errors;
		stored = 64'h0105_5aa5_c33c_0105;
		run_request("dirty store", 1'b1, 16'h0105, stored, latency);
		run_request("second tag", 1'b0, 16'h0205, '0, latency);
		run_request("third tag", 1'b0, 16'h0305, '0, latency);
		check_value("writeback record", 128'({MEM_STORE, 16'h0105, stored}),
			128'(last_store));
		check_value("writeback count", 128'(1), 128'(writeback_count));
		run_request("reload", 1'b0, 16'h0105, '0, latency);
		check_value("reload value", 128'(stored), 128'(resp_data));
		report_test("eviction and writeback", mark);

		mark = errors;
		random_traffic("random traffic", RANDOM_REQUESTS / 2);
		report_test("random traffic", mark);

		mark = errors;
		refusal_on = 1'b1;
		random_traffic("back-pressure", RANDOM_REQUESTS - RANDOM_REQUESTS / 2);
		refusal_on = 1'b0;
		report_test("back-pressure", mark);

		mark = errors;
		check_value("hit count", 128'(model_hits), 128'(hit_count));
		check_value("miss count", 128'(model_misses), 128'(miss_count));
		check_value("writeback count", 128'(model_writebacks), 128'(writeback_count));
		report_test("counters", mark);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: compile.f
+incdir+include
rtl/dcache_pkg.sv
rtl/dcache_if.sv
rtl/dcache_ctrl.sv
rtl/dcache_mem.sv
rtl/dcache_resp.sv
rtl/dcache_top.sv
test/mem_model.sv
test/dcache_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -j 0
TOP ?= dcache_tb
FILE_LIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MESSAGE = *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MESSAGE)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
